// File: hw/of_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OpenFlow datapath package
// Widths, payload types, flow table size and the controller
// port shared by the three pipeline stages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package of_pkg;

   // Stream and table geometry
   localparam int DATA_W    = 64;
   localparam int KEY_W     = 32;
   localparam int PORT_W    = 3;
   localparam int TBL_DEPTH = 4;
   localparam int IDX_W     = 2;
   localparam int CNT_W     = 32;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [KEY_W-1:0]  flow_key_t;
   typedef logic [PORT_W-1:0] port_t;
   typedef logic [IDX_W-1:0]  tbl_idx_t;

   // Wraps at the top, no saturation
   typedef logic [CNT_W-1:0] count_t;

   // Bit 3 is the drop flag, bits 2:0 the output port
   typedef logic [PORT_W:0] of_action_t;

   // Table misses go here
   localparam port_t CPU_PORT = 3'd4;

   // Position inside a packet
   typedef enum logic {
      PKT_IDLE,
      PKT_BODY
   } pkt_state_e;

endpackage

// File: hw/beat_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream beat link between pipeline stages
// Carries one data beat with last and start-of-packet marks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface beat_if;

   of_pkg::data_t tdata;
   logic          tvalid;
   logic          tlast;
   // High on the first beat of a packet only
   logic          sop;
   logic          tready;

   modport src (
      output tdata,
      output tvalid,
      output tlast,
      output sop,
      input  tready
   );

   modport dst (
      input  tdata,
      input  tvalid,
      input  tlast,
      input  sop,
      output tready
   );

endinterface

// File: hw/header_parser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header parser, pipeline stage 1
// Registers input beats, marks packet starts, extracts the
// flow key and counts parsed packets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module header_parser (
   input  logic              asclk,
   input  logic              rst_n,
   input  of_pkg::data_t     s_tdata,
   input  logic              s_tvalid,
   input  logic              s_tlast,
   output logic              s_tready,
   beat_if.src               out,
   output of_pkg::flow_key_t key,
   output of_pkg::count_t    parse_count
);

   of_pkg::pkt_state_e pkt_state;
   logic               run;
   logic               accept;
   logic               first_beat;

   // Refill when empty or when the held beat leaves this cycle
   assign s_tready   = run && (!out.tvalid || out.tready);
   assign accept     = s_tvalid && s_tready;
   assign first_beat = (pkt_state == of_pkg::PKT_IDLE);

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         run         <= 1'b0;
         pkt_state   <= of_pkg::PKT_IDLE;
         out.tvalid  <= 1'b0;
         parse_count <= '0;
      end else begin
         // Input opens one cycle after reset release
         run <= 1'b1;
         if (accept) begin
            out.tvalid <= 1'b1;
            pkt_state  <= s_tlast ? of_pkg::PKT_IDLE : of_pkg::PKT_BODY;
            if (first_beat) begin
               parse_count <= parse_count + 1'b1;
            end
         end else if (out.tready) begin
            out.tvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge asclk) begin
      if (accept) begin
         out.tdata <= s_tdata;
         out.tlast <= s_tlast;
         out.sop   <= first_beat;
         // Key is the upper half of the first beat
         if (first_beat) begin
            key <= s_tdata[of_pkg::DATA_W-1 -: of_pkg::KEY_W];
         end
      end
   end

   // Upstream holds a stalled beat
   assert property (@(posedge asclk) disable iff (!rst_n)
      s_tvalid && !s_tready |=> $stable(s_tdata));

endmodule

// File: hw/flow_lookup.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flow lookup, pipeline stage 2
// Four-entry exact-match flow table written by the host.
// Matches the key on each packet start, attaches the action
// and counts hits and misses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module flow_lookup (
   input  logic               asclk,
   input  logic               rst_n,
   beat_if.dst                in,
   input  of_pkg::flow_key_t  key,
   input  logic               tbl_wr,
   input  of_pkg::tbl_idx_t   tbl_index,
   input  of_pkg::flow_key_t  tbl_key,
   input  of_pkg::of_action_t tbl_action,
   input  logic               tbl_valid,
   beat_if.src                out,
   output of_pkg::of_action_t action,
   output of_pkg::count_t     hit_count,
   output of_pkg::count_t     miss_count
);

   logic [of_pkg::TBL_DEPTH-1:0] tbl_vld;
   of_pkg::flow_key_t            tbl_key_q [of_pkg::TBL_DEPTH];
   of_pkg::of_action_t           tbl_act_q [of_pkg::TBL_DEPTH];
   logic                         lu_hit;
   of_pkg::of_action_t           lu_action;
   logic                         accept;
   logic                         pkt_open;

   assign in.tready = !out.tvalid || out.tready;
   assign accept    = in.tvalid && in.tready;

   // Host writes, a clear valid bit removes the entry
   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         tbl_vld <= '0;
      end else if (tbl_wr) begin
         tbl_vld[tbl_index] <= tbl_valid;
      end
   end

   always_ff @(posedge asclk) begin
      if (tbl_wr) begin
         tbl_key_q[tbl_index] <= tbl_key;
         tbl_act_q[tbl_index] <= tbl_action;
      end
   end

   // Scan from the top so the lowest matching index wins
   always_comb begin
      lu_hit    = 1'b0;
      lu_action = {1'b0, of_pkg::CPU_PORT};
      for (int i = of_pkg::TBL_DEPTH - 1; i >= 0; i--) begin
         if (tbl_vld[i] && (tbl_key_q[i] == key)) begin
            lu_hit    = 1'b1;
            lu_action = tbl_act_q[i];
         end
      end
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         out.tvalid <= 1'b0;
         pkt_open   <= 1'b0;
         hit_count  <= '0;
         miss_count <= '0;
      end else begin
         if (accept) begin
            out.tvalid <= 1'b1;
            pkt_open   <= !in.tlast;
            if (in.sop && lu_hit) begin
               hit_count <= hit_count + 1'b1;
            end else if (in.sop) begin
               miss_count <= miss_count + 1'b1;
            end
         end else if (out.tready) begin
            out.tvalid <= 1'b0;
         end
      end
   end

   // Action stays put for the rest of the packet
   always_ff @(posedge asclk) begin
      if (accept) begin
         out.tdata <= in.tdata;
         out.tlast <= in.tlast;
         out.sop   <= in.sop;
         if (in.sop) begin
            action <= lu_action;
         end
      end
   end

   // Parser marks only the beat after a tlast as a start
   assert property (@(posedge asclk) disable iff (!rst_n)
      in.tvalid && in.sop |-> !pkt_open);

endmodule

// File: hw/action_apply.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Action apply, pipeline stage 3
// Forwards whole packets with their output port or drops
// them, and counts dropped packets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module action_apply (
   input  logic               asclk,
   input  logic               rst_n,
   beat_if.dst                in,
   input  of_pkg::of_action_t action,
   output of_pkg::data_t      m_tdata,
   output logic               m_tvalid,
   output logic               m_tlast,
   input  logic               m_tready,
   output of_pkg::port_t      m_port,
   output of_pkg::count_t     drop_count
);

   of_pkg::pkt_state_e pkt_state;
   logic               drop_q;
   logic               drop_now;
   logic               accept;

   // Drop flag taken at the packet start, kept for the body
   assign drop_now = (pkt_state == of_pkg::PKT_IDLE) ? action[of_pkg::PORT_W] : drop_q;

   // Dropped beats never wait on the output
   assign in.tready = drop_now || !m_tvalid || m_tready;
   assign accept    = in.tvalid && in.tready;

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         pkt_state  <= of_pkg::PKT_IDLE;
         drop_q     <= 1'b0;
         m_tvalid   <= 1'b0;
         drop_count <= '0;
      end else begin
         if (accept) begin
            pkt_state <= in.tlast ? of_pkg::PKT_IDLE : of_pkg::PKT_BODY;
            drop_q    <= drop_now;
            if (in.sop && drop_now) begin
               drop_count <= drop_count + 1'b1;
            end
         end
         if (accept && !drop_now) begin
            m_tvalid <= 1'b1;
         end else if (m_tready) begin
            m_tvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge asclk) begin
      if (accept && !drop_now) begin
         m_tdata <= in.tdata;
         m_tlast <= in.tlast;
         m_port  <= action[of_pkg::PORT_W-1:0];
      end
   end

   // Output beat held under back-pressure
   assert property (@(posedge asclk) disable iff (!rst_n)
      m_tvalid && !m_tready |=>
         $stable(m_tdata) && $stable(m_tlast) && $stable(m_port));

endmodule

// File: hw/of_datapath.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OpenFlow datapath top level
// Parser, exact-match lookup and action stages in a
// three-deep pipeline on one 64-bit packet stream
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module of_datapath (
   input  logic               asclk,
   input  logic               rst_n,
   // Stream in
   input  of_pkg::data_t      s_tdata,
   input  logic               s_tvalid,
   input  logic               s_tlast,
   output logic               s_tready,
   // Stream out
   output of_pkg::data_t      m_tdata,
   output logic               m_tvalid,
   output logic               m_tlast,
   input  logic               m_tready,
   output of_pkg::port_t      m_port,
   // Flow table write
   input  logic               tbl_wr,
   input  of_pkg::tbl_idx_t   tbl_index,
   input  of_pkg::flow_key_t  tbl_key,
   input  of_pkg::of_action_t tbl_action,
   input  logic               tbl_valid,
   // Statistics
   output of_pkg::count_t     parse_count,
   output of_pkg::count_t     hit_count,
   output of_pkg::count_t     miss_count,
   output of_pkg::count_t     drop_count
);

   of_pkg::flow_key_t  key;
   of_pkg::of_action_t action;

   beat_if parsed ();
   beat_if looked_up ();

   header_parser u_parser (
      .asclk       (asclk),
      .rst_n       (rst_n),
      .s_tdata     (s_tdata),
      .s_tvalid    (s_tvalid),
      .s_tlast     (s_tlast),
      .s_tready    (s_tready),
      .out         (parsed.src),
      .key         (key),
      .parse_count (parse_count)
   );

   flow_lookup u_lookup (
      .asclk      (asclk),
      .rst_n      (rst_n),
      .in         (parsed.dst),
      .key        (key),
      .tbl_wr     (tbl_wr),
      .tbl_index  (tbl_index),
      .tbl_key    (tbl_key),
      .tbl_action (tbl_action),
      .tbl_valid  (tbl_valid),
      .out        (looked_up.src),
      .action     (action),
      .hit_count  (hit_count),
      .miss_count (miss_count)
   );

   action_apply u_action (
      .asclk      (asclk),
      .rst_n      (rst_n),
      .in         (looked_up.dst),
      .action     (action),
      .m_tdata    (m_tdata),
      .m_tvalid   (m_tvalid),
      .m_tlast    (m_tlast),
      .m_tready   (m_tready),
      .m_port     (m_port),
      .drop_count (drop_count)
   );

endmodule

// File: verification/tb_of_datapath.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the OpenFlow datapath
// Directed tests for lookup hit, miss, drop, table priority
// and output back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_of_datapath;

   localparam int PERIOD  = 40;
   localparam int TIMEOUT = 200;
   localparam of_pkg::flow_key_t K_FWD  = 32'hc0a80001;
   localparam of_pkg::flow_key_t K_MISS = 32'h0a000063;
   localparam of_pkg::flow_key_t K_DROP = 32'hac100007;
   localparam of_pkg::flow_key_t K_PRIO = 32'hc0a8002a;

   logic               asclk;
   logic               rst_n;
   of_pkg::data_t      s_tdata;
   logic               s_tvalid;
   logic               s_tlast;
   logic               s_tready;
   of_pkg::data_t      m_tdata;
   logic               m_tvalid;
   logic               m_tlast;
   logic               m_tready;
   of_pkg::port_t      m_port;
   logic               tbl_wr;
   of_pkg::tbl_idx_t   tbl_index;
   of_pkg::flow_key_t  tbl_key;
   of_pkg::of_action_t tbl_action;
   logic               tbl_valid;
   of_pkg::count_t     parse_count;
   of_pkg::count_t     hit_count;
   of_pkg::count_t     miss_count;
   of_pkg::count_t     drop_count;

   int                 seed;
   logic               bp_on;
   time                acc_time;
   time                out_time;
   // Packet beats and where each packet sits
   of_pkg::data_t      beat_mem [64];
   int                 next_beat;
   int                 pkt_start [16];
   int                 pkt_len [16];
   // Reference flow table and expected counters
   logic               mdl_valid [of_pkg::TBL_DEPTH];
   of_pkg::flow_key_t  mdl_key [of_pkg::TBL_DEPTH];
   of_pkg::of_action_t mdl_act [of_pkg::TBL_DEPTH];
   int                 exp_parse;
   int                 exp_hit;
   int                 exp_miss;
   int                 exp_drop;

   of_datapath i_dut (.*);

   initial begin
      asclk = 1'b0;
      forever #(PERIOD / 2) asclk = ~asclk;
   end

   // Output ready, random while back-pressure is on
   initial begin
      forever begin
         @(negedge asclk);
         if (bp_on) begin
            m_tready = ($random(seed) & 1) != 0;
         end else begin
            m_tready = 1'b1;
         end
      end
   end

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAIL");
         $fatal(1, "Check failed");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at %0t: %s", $time, what);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped after a timeout");
   endtask

   task automatic check_counters();
      check("parse_count", parse_count, exp_parse);
      check("hit_count", hit_count, exp_hit);
      check("miss_count", miss_count, exp_miss);
      check("drop_count", drop_count, exp_drop);
   endtask

   task automatic write_entry(input of_pkg::tbl_idx_t idx, input of_pkg::flow_key_t key,
                              input of_pkg::of_action_t act, input logic vld);
      @(negedge asclk);
      tbl_wr     = 1'b1;
      tbl_index  = idx;
      tbl_key    = key;
      tbl_action = act;
      tbl_valid  = vld;
      @(negedge asclk);
      tbl_wr         = 1'b0;
      mdl_valid[idx] = vld;
      mdl_key[idx]   = key;
      mdl_act[idx]   = act;
   endtask

   // Lowest valid index with an equal key, or -1
   function automatic int find_entry(input of_pkg::flow_key_t key);
      for (int i = 0; i < of_pkg::TBL_DEPTH; i++) begin
         if (mdl_valid[i] && mdl_key[i] == key) begin
            return i;
         end
      end
      return -1;
   endfunction

   task automatic build_packet(input int p, input int len, input of_pkg::flow_key_t key);
      pkt_start[p] = next_beat;
      pkt_len[p]   = len;
      for (int i = 0; i < len; i++) begin
         beat_mem[next_beat + i] = {$random(seed), $random(seed)};
      end
      beat_mem[next_beat][of_pkg::DATA_W-1 -: of_pkg::KEY_W] = key;
      next_beat += len;
   endtask

   task automatic send_packet(input int first, input int len);
      int waited;
      for (int i = 0; i < len; i++) begin
         @(negedge asclk);
         s_tvalid = 1'b1;
         s_tdata  = beat_mem[first + i];
         s_tlast  = (i == len - 1);
         waited   = 0;
         #(PERIOD / 4);
         while (!s_tready) begin
            waited++;
            if (waited > TIMEOUT) begin
               report_timeout("input stream never became ready");
            end
            @(negedge asclk);
            #(PERIOD / 4);
         end
         if (i == 0) begin
            acc_time = $time;
         end
         @(posedge asclk);
      end
      @(negedge asclk);
      s_tvalid = 1'b0;
      s_tlast  = 1'b0;
   endtask

   task automatic expect_packet(input int first, input int len, input of_pkg::port_t port);
      int waited;
      for (int i = 0; i < len; i++) begin
         waited = 0;
         @(negedge asclk);
         #(PERIOD / 4);
         while (!(m_tvalid && m_tready)) begin
            waited++;
            if (waited > TIMEOUT) begin
               report_timeout("expected output beat never arrived");
            end
            @(negedge asclk);
            #(PERIOD / 4);
         end
         if (i == 0) begin
            out_time = $time;
         end
         check("m_tdata", m_tdata, beat_mem[first + i]);
         check("m_tlast", m_tlast, i == len - 1);
         check("m_port", m_port, port);
      end
   endtask

   // Sends packets back to back and checks whatever must come out
   task automatic stream_packets(input int from, input int count);
      of_pkg::of_action_t act [16];
      int                 idx;
      for (int p = from; p < from + count; p++) begin
         idx    = find_entry(beat_mem[pkt_start[p]][of_pkg::DATA_W-1 -: of_pkg::KEY_W]);
         act[p] = (idx < 0) ? {1'b0, of_pkg::CPU_PORT} : mdl_act[idx];
         exp_parse++;
         if (idx < 0) begin
            exp_miss++;
         end else begin
            exp_hit++;
         end
         if (act[p][of_pkg::PORT_W]) begin
            exp_drop++;
         end
      end
      fork
         begin
            for (int p = from; p < from + count; p++) begin
               send_packet(pkt_start[p], pkt_len[p]);
            end
         end
         begin
            for (int p = from; p < from + count; p++) begin
               if (!act[p][of_pkg::PORT_W]) begin
                  expect_packet(pkt_start[p], pkt_len[p], act[p][of_pkg::PORT_W-1:0]);
               end
            end
         end
      join
      // Trailing dropped beats reach stage 3 within the pipeline depth
      repeat (3) @(negedge asclk);
      check("m_tvalid", m_tvalid, 1'b0);
   endtask

   task automatic test_reset();
      check("m_tvalid", m_tvalid, 1'b0);
      check_counters();
   endtask

   task automatic test_hit();
      write_entry(0, K_FWD, 4'h2, 1'b1);
      build_packet(0, 3, K_FWD);
      stream_packets(0, 1);
      check("m_port", m_port, 2);
      // Input sample to output sample, three clock cycles
      check("first beat latency", out_time - acc_time, 3 * PERIOD);
      check_counters();
   endtask

   task automatic test_miss();
      build_packet(1, 2, K_MISS);
      stream_packets(1, 1);
      check("m_port", m_port, of_pkg::CPU_PORT);
      check_counters();
   endtask

   // A stray beat of the dropped packet would fail the data check
   task automatic test_drop();
      write_entry(1, K_DROP, 4'b1011, 1'b1);
      build_packet(2, 4, K_DROP);
      build_packet(3, 2, K_FWD);
      stream_packets(2, 2);
      check_counters();
   endtask

   task automatic test_priority();
      write_entry(1, K_PRIO, 4'h5, 1'b1);
      write_entry(3, K_PRIO, 4'h6, 1'b1);
      build_packet(4, 2, K_PRIO);
      stream_packets(4, 1);
      check("m_port", m_port, 5);
      write_entry(1, K_PRIO, 4'h5, 1'b0);
      build_packet(5, 2, K_PRIO);
      stream_packets(5, 1);
      check("m_port", m_port, 6);
      check_counters();
   endtask

   task automatic test_backpressure();
      of_pkg::flow_key_t keys [4];
      int                len;
      int                pick;
      keys = '{K_FWD, K_MISS, K_DROP, K_PRIO};
      write_entry(2, K_DROP, 4'b1000, 1'b1);
      for (int p = 6; p < 14; p++) begin
         len  = 1 + int'($unsigned($random(seed)) % 4);
         pick = int'($unsigned($random(seed)) % 4);
         build_packet(p, len, keys[pick]);
      end
      bp_on = 1'b1;
      stream_packets(6, 8);
      bp_on = 1'b0;
      check_counters();
   endtask

   initial begin
      seed       = 32'hd7f7d041;
      rst_n      = 1'b0;
      s_tdata    = '0;
      s_tvalid   = 1'b0;
      s_tlast    = 1'b0;
      m_tready   = 1'b1;
      tbl_wr     = 1'b0;
      tbl_index  = '0;
      tbl_key    = '0;
      tbl_action = '0;
      tbl_valid  = 1'b0;
      bp_on      = 1'b0;
      next_beat  = 0;
      exp_parse  = 0;
      exp_hit    = 0;
      exp_miss   = 0;
      exp_drop   = 0;
      for (int i = 0; i < of_pkg::TBL_DEPTH; i++) begin
         mdl_valid[i] = 1'b0;
      end
      repeat (10) @(negedge asclk);
      rst_n = 1'b1;
      test_reset();
      test_hit();
      test_miss();
      test_drop();
      test_priority();
      test_backpressure();
      $display("TEST PASS");
      $finish;
   end

endmodule

// File: of_datapath.f
hw/of_pkg.sv
hw/beat_if.sv
hw/header_parser.sv
hw/flow_lookup.sv
hw/action_apply.sv
hw/of_datapath.sv
verification/tb_of_datapath.sv

// File: Makefile
# Verilator build, run and lint for the OpenFlow datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_of_datapath
RTL_TOP   ?= of_datapath
FILELIST  ?= of_datapath.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run result comes from the log, not from the exit status
run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
